//--- src/cpu_cfg.svh
`ifndef CPU_CFG_SVH
`define CPU_CFG_SVH

// Datapath and address width
`define CPU_XLEN 32

// Architectural register count, register 0 reads as zero
`define CPU_REG_COUNT 32

// First fetch address after reset
`define CPU_RESET_PC 32'h0000_0000

// Bytes per instruction
`define CPU_PC_STEP 32'd4

`endif

//--- src/cpu_pkg.sv
`default_nettype none

`include "cpu_cfg.svh"

package cpu_pkg;

    typedef logic [`CPU_XLEN-1:0] word_t;
    typedef logic [$clog2(`CPU_REG_COUNT)-1:0] reg_addr_t;

    typedef enum logic [5:0] {
        OP_RTYPE = 6'h00,
        OP_J     = 6'h02,
        OP_BEQ   = 6'h04,
        OP_BNE   = 6'h05,
        OP_ADDIU = 6'h09,
        OP_LW    = 6'h23,
        OP_SW    = 6'h2b
    } opcode_t;

    typedef enum logic [5:0] {
        FN_ADDU = 6'h21,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_XOR  = 6'h26,
        FN_SLT  = 6'h2a
    } funct_t;

    typedef enum logic [2:0] {
        ALU_ADD,                        // Zero so a cleared ctrl_t means add
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT
    } alu_op_t;

    typedef enum logic [1:0] {
        FWD_REG = 2'd0,                 // Value read in decode
        FWD_ME  = 2'd1,                 // ALU result sitting in memory stage
        FWD_WB  = 2'd2                  // Data being written back
    } fwd_sel_t;

    typedef struct packed {
        logic    alu_src;               // Immediate as second operand
        alu_op_t alu_op;
        logic    mem_read;
        logic    mem_write;
        logic    mem_to_reg;            // Write back load data instead of ALU result
        logic    reg_write;
    } ctrl_t;

    typedef struct packed {
        word_t instr;
        word_t pc_plus4;
    } if_id_t;

    typedef struct packed {
        ctrl_t     ctrl;
        reg_addr_t rs;
        reg_addr_t rt;
        reg_addr_t dst;                 // Zero when nothing is written
        word_t     rs_val;
        word_t     rt_val;
        word_t     imm;                 // Sign-extended
    } id_ex_t;

    typedef struct packed {
        logic      mem_read;
        logic      mem_write;
        logic      mem_to_reg;
        logic      reg_write;
        word_t     alu_result;          // Also the data address
        word_t     store_data;
        reg_addr_t dst;
    } ex_me_t;

    typedef struct packed {
        logic      reg_write;
        logic      mem_to_reg;
        word_t     load_data;
        word_t     alu_result;
        reg_addr_t dst;
    } me_wb_t;

    // Operand bypass mux, shared by decode and execute
    function automatic word_t fwd_mux(
        input fwd_sel_t sel,
        input word_t    reg_val,
        input word_t    me_val,
        input word_t    wb_val
    );
        case (sel)
            FWD_ME:  return me_val;
            FWD_WB:  return wb_val;
            default: return reg_val;
        endcase
    endfunction

endpackage

`default_nettype wire

//--- src/pipe_reg.sv
`timescale 1ns/1ps
`default_nettype none

module pipe_reg #(
    parameter type T = logic
) (
    input  logic clock,
    input  logic rst_n,
    input  logic hold,                  // Keep current contents
    input  logic bubble,                // Load a no-operation
    input  T     d,
    output T     q
);

    // All-zero payload has every write enable low
    always_ff @(posedge clock) begin
        if (!rst_n || bubble) begin
            q <= '0;
        end else if (!hold) begin
            q <= d;
        end
    end

endmodule

`default_nettype wire

//--- src/fetch_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_cfg.svh"

module fetch_stage import cpu_pkg::*; (
    input  logic  clock,
    input  logic  rst_n,
    input  logic  stall,                // Hazard unit holds fetch
    input  logic  take_target,          // Taken branch or jump in decode
    input  word_t target,
    output word_t pc,
    output word_t pc_plus4
);

    assign pc_plus4 = pc + `CPU_PC_STEP; // Sequential address

    // Redirect lands after the delay slot has been fetched
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            pc <= `CPU_RESET_PC;
        end else if (!stall) begin
            if (take_target) begin
                pc <= target;
            end else begin
                pc <= pc_plus4;
            end
        end
    end

endmodule

`default_nettype wire

//--- src/register_file.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_cfg.svh"

module register_file import cpu_pkg::*; (
    input  logic      clock,
    input  logic      rst_n,
    input  reg_addr_t rs_addr,
    input  reg_addr_t rt_addr,
    input  reg_addr_t wr_addr,
    input  logic      wr_en,
    input  word_t     wr_data,
    output word_t     rs_data,
    output word_t     rt_data
);

    word_t regs [`CPU_REG_COUNT];       // Storage, entry 0 never read

    // Write at the edge that ends write-back, nothing lands while in reset
    always_ff @(posedge clock) begin
        if (rst_n && wr_en && (wr_addr != '0)) begin
            regs[wr_addr] <= wr_data;
        end
    end

    assign rs_data = (rs_addr == '0) ? '0 : regs[rs_addr]; // Hardwired zero
    assign rt_data = (rt_addr == '0) ? '0 : regs[rt_addr];

endmodule

`default_nettype wire

//--- src/decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

module decode_stage import cpu_pkg::*; (
    input  if_id_t    if_id,
    input  word_t     rs_data,
    input  word_t     rt_data,
    input  word_t     me_result,
    input  word_t     wb_data,
    input  fwd_sel_t  fwd_rs,
    input  fwd_sel_t  fwd_rt,
    output reg_addr_t rs_addr,
    output reg_addr_t rt_addr,
    output id_ex_t    id_ex,
    output logic      take_target,
    output word_t     target,
    output logic      is_branch
);

    word_t     instr;
    opcode_t   opcode;
    funct_t    funct;
    reg_addr_t rd_addr;
    word_t     imm;
    word_t     rs_val;
    word_t     rt_val;
    word_t     branch_target;
    word_t     jump_target;
    ctrl_t     ctrl;
    reg_addr_t dst;
    logic      is_jump;
    logic      ops_equal;

    assign instr   = if_id.instr;
    assign opcode  = opcode_t'(instr[31:26]);
    assign funct   = funct_t'(instr[5:0]);
    assign rs_addr = instr[25:21];
    assign rt_addr = instr[20:16];
    assign rd_addr = instr[15:11];
    assign imm     = {{16{instr[15]}}, instr[15:0]}; // Sign extend

    // Bypassed operands feed both the compare and ID/EX
    assign rs_val    = fwd_mux(fwd_rs, rs_data, me_result, wb_data);
    assign rt_val    = fwd_mux(fwd_rt, rt_data, me_result, wb_data);
    assign ops_equal = (rs_val == rt_val);

    assign branch_target = if_id.pc_plus4 + {imm[29:0], 2'b00}; // Word offset from delay slot
    assign jump_target   = {if_id.pc_plus4[31:28], instr[25:0], 2'b00}; // Region kept from PC

    always_comb begin
        ctrl      = '0;                 // Unknown encodings decode as no-operation
        dst       = '0;
        is_branch = 1'b0;
        is_jump   = 1'b0;
        case (opcode)
            OP_RTYPE: begin
                ctrl.reg_write = 1'b1;
                dst            = rd_addr; // R-type writes rd
                case (funct)
                    FN_ADDU: ctrl.alu_op = ALU_ADD;
                    FN_SUBU: ctrl.alu_op = ALU_SUB;
                    FN_AND:  ctrl.alu_op = ALU_AND;
                    FN_OR:   ctrl.alu_op = ALU_OR;
                    FN_XOR:  ctrl.alu_op = ALU_XOR;
                    FN_SLT:  ctrl.alu_op = ALU_SLT;
                    default: begin
                        ctrl.reg_write = 1'b0;
                        dst            = '0;
                    end
                endcase
            end
            OP_ADDIU: begin
                ctrl.alu_src   = 1'b1;
                ctrl.reg_write = 1'b1;
                dst            = rt_addr;
            end
            OP_LW: begin
                ctrl.alu_src    = 1'b1; // Address is base plus offset
                ctrl.mem_read   = 1'b1;
                ctrl.mem_to_reg = 1'b1;
                ctrl.reg_write  = 1'b1;
                dst             = rt_addr;
            end
            OP_SW: begin
                ctrl.alu_src   = 1'b1;
                ctrl.mem_write = 1'b1;
            end
            OP_BEQ, OP_BNE: is_branch = 1'b1;
            OP_J:           is_jump   = 1'b1;
            default: ;
        endcase
    end

    // BNE inverts the equality test
    assign take_target = is_jump | (is_branch & (ops_equal ^ (opcode == OP_BNE)));
    assign target      = is_jump ? jump_target : branch_target;

    assign id_ex = '{
        ctrl:   ctrl,
        rs:     rs_addr,
        rt:     rt_addr,
        dst:    dst,
        rs_val: rs_val,
        rt_val: rt_val,
        imm:    imm
    };

endmodule

`default_nettype wire

//--- src/hazard_unit.sv
`timescale 1ns/1ps
`default_nettype none

module hazard_unit import cpu_pkg::*; (
    input  reg_addr_t id_rs,
    input  reg_addr_t id_rt,
    input  logic      id_is_branch,
    input  id_ex_t    ex_stage,
    input  ex_me_t    me_stage,
    input  me_wb_t    wb_stage,
    output logic      stall,
    output fwd_sel_t  id_fwd_rs,
    output fwd_sel_t  id_fwd_rt,
    output fwd_sel_t  ex_fwd_rs,
    output fwd_sel_t  ex_fwd_rt
);

    logic id_me_ok;                     // ME result usable in decode
    logic load_use;
    logic branch_ex;
    logic branch_load;

    // Youngest producer wins, register 0 is never bypassed
    function automatic fwd_sel_t pick(
        input reg_addr_t src,
        input logic      me_en,
        input reg_addr_t me_dst,
        input logic      wb_en,
        input reg_addr_t wb_dst
    );
        if (src == '0) return FWD_REG;
        if (me_en && (me_dst == src)) return FWD_ME;
        if (wb_en && (wb_dst == src)) return FWD_WB;
        return FWD_REG;
    endfunction

    function automatic logic hits(input reg_addr_t dst, input reg_addr_t a, input reg_addr_t b);
        return (dst != '0) && ((dst == a) || (dst == b));
    endfunction

    // A load in ME only has its address, never bypass that
    assign id_me_ok = me_stage.reg_write & ~me_stage.mem_read;

    assign id_fwd_rs = pick(id_rs, id_me_ok, me_stage.dst, wb_stage.reg_write, wb_stage.dst);
    assign id_fwd_rt = pick(id_rt, id_me_ok, me_stage.dst, wb_stage.reg_write, wb_stage.dst);
    assign ex_fwd_rs = pick(ex_stage.rs, me_stage.reg_write, me_stage.dst,
                            wb_stage.reg_write, wb_stage.dst);
    assign ex_fwd_rt = pick(ex_stage.rt, me_stage.reg_write, me_stage.dst,
                            wb_stage.reg_write, wb_stage.dst);

    assign load_use    = ex_stage.ctrl.mem_read & hits(ex_stage.dst, id_rs, id_rt); // Covers store data too
    assign branch_ex   = id_is_branch & ex_stage.ctrl.reg_write & hits(ex_stage.dst, id_rs, id_rt);
    assign branch_load = id_is_branch & me_stage.mem_read & hits(me_stage.dst, id_rs, id_rt);

    assign stall = load_use | branch_ex | branch_load;

endmodule

`default_nettype wire

//--- src/execute_stage.sv
`timescale 1ns/1ps
`default_nettype none

module execute_stage import cpu_pkg::*; (
    input  id_ex_t   id_ex,
    input  word_t    me_result,
    input  word_t    wb_data,
    input  fwd_sel_t fwd_rs,
    input  fwd_sel_t fwd_rt,
    output ex_me_t   ex_me
);

    word_t op_a;
    word_t rt_fwd;                      // Also the store data
    word_t op_b;
    word_t alu_y;

    assign op_a   = fwd_mux(fwd_rs, id_ex.rs_val, me_result, wb_data);
    assign rt_fwd = fwd_mux(fwd_rt, id_ex.rt_val, me_result, wb_data);
    assign op_b   = id_ex.ctrl.alu_src ? id_ex.imm : rt_fwd; // Immediate forms

    always_comb begin
        case (id_ex.ctrl.alu_op)
            ALU_ADD: alu_y = op_a + op_b; // No overflow trap
            ALU_SUB: alu_y = op_a - op_b;
            ALU_AND: alu_y = op_a & op_b;
            ALU_OR:  alu_y = op_a | op_b;
            ALU_XOR: alu_y = op_a ^ op_b;
            ALU_SLT: alu_y = word_t'($signed(op_a) < $signed(op_b)); // Signed compare
            default: alu_y = op_a + op_b;
        endcase
    end

    assign ex_me = '{
        mem_read:   id_ex.ctrl.mem_read,
        mem_write:  id_ex.ctrl.mem_write,
        mem_to_reg: id_ex.ctrl.mem_to_reg,
        reg_write:  id_ex.ctrl.reg_write,
        alu_result: alu_y,
        store_data: rt_fwd,
        dst:        id_ex.dst
    };

endmodule

`default_nettype wire

//--- src/mips_pipeline.sv
`timescale 1ns/1ps
`default_nettype none

module mips_pipeline import cpu_pkg::*; (
    input  logic  clock,
    input  logic  rst_n,
    output word_t inst_addr,
    input  word_t inst_data,
    output word_t dmem_addr,
    output word_t dmem_wdata,
    output logic  dmem_write,
    output logic  dmem_read,
    input  word_t dmem_rdata
);

    word_t     pc;
    word_t     pc_plus4;
    logic      stall;
    logic      take_target;
    word_t     target;
    logic      is_branch;
    reg_addr_t rs_addr;
    reg_addr_t rt_addr;
    word_t     rs_data;
    word_t     rt_data;
    word_t     wb_data;
    fwd_sel_t  id_fwd_rs;
    fwd_sel_t  id_fwd_rt;
    fwd_sel_t  ex_fwd_rs;
    fwd_sel_t  ex_fwd_rt;
    if_id_t    if_id_d;
    if_id_t    if_id_q;
    id_ex_t    id_ex_d;
    id_ex_t    id_ex_q;
    ex_me_t    ex_me_d;
    ex_me_t    ex_me_q;
    me_wb_t    me_wb_d;
    me_wb_t    me_wb_q;

    fetch_stage u_fetch (
        .clock       (clock),
        .rst_n       (rst_n),
        .stall       (stall),
        .take_target (take_target),
        .target      (target),
        .pc          (pc),
        .pc_plus4    (pc_plus4)
    );

    assign inst_addr = pc;
    assign if_id_d   = '{instr: inst_data, pc_plus4: pc_plus4};

    pipe_reg #(.T(if_id_t)) u_if_id (
        .clock (clock), .rst_n (rst_n),
        .hold  (stall),                 // Decode retries the same instruction
        .bubble(1'b0),
        .d     (if_id_d), .q (if_id_q)
    );

    register_file u_regs (
        .clock   (clock),
        .rst_n   (rst_n),
        .rs_addr (rs_addr),
        .rt_addr (rt_addr),
        .wr_addr (me_wb_q.dst),
        .wr_en   (me_wb_q.reg_write),
        .wr_data (wb_data),
        .rs_data (rs_data),
        .rt_data (rt_data)
    );

    decode_stage u_decode (
        .if_id       (if_id_q),
        .rs_data     (rs_data),
        .rt_data     (rt_data),
        .me_result   (ex_me_q.alu_result),
        .wb_data     (wb_data),
        .fwd_rs      (id_fwd_rs),
        .fwd_rt      (id_fwd_rt),
        .rs_addr     (rs_addr),
        .rt_addr     (rt_addr),
        .id_ex       (id_ex_d),
        .take_target (take_target),
        .target      (target),
        .is_branch   (is_branch)
    );

    hazard_unit u_hazard (
        .id_rs        (rs_addr),
        .id_rt        (rt_addr),
        .id_is_branch (is_branch),
        .ex_stage     (id_ex_q),
        .me_stage     (ex_me_q),
        .wb_stage     (me_wb_q),
        .stall        (stall),
        .id_fwd_rs    (id_fwd_rs),
        .id_fwd_rt    (id_fwd_rt),
        .ex_fwd_rs    (ex_fwd_rs),
        .ex_fwd_rt    (ex_fwd_rt)
    );

    pipe_reg #(.T(id_ex_t)) u_id_ex (
        .clock (clock), .rst_n (rst_n),
        .hold  (1'b0),
        .bubble(stall),                 // Stalled instruction stays in decode
        .d     (id_ex_d), .q (id_ex_q)
    );

    execute_stage u_execute (
        .id_ex     (id_ex_q),
        .me_result (ex_me_q.alu_result),
        .wb_data   (wb_data),
        .fwd_rs    (ex_fwd_rs),
        .fwd_rt    (ex_fwd_rt),
        .ex_me     (ex_me_d)
    );

    pipe_reg #(.T(ex_me_t)) u_ex_me (
        .clock (clock), .rst_n (rst_n),
        .hold  (1'b0), .bubble (1'b0),
        .d     (ex_me_d), .q (ex_me_q)
    );

    // Memory stage drives the data port straight from EX/ME
    assign dmem_addr  = ex_me_q.alu_result;
    assign dmem_wdata = ex_me_q.store_data;
    assign dmem_write = ex_me_q.mem_write; // One cycle per store
    assign dmem_read  = ex_me_q.mem_read;

    assign me_wb_d = '{
        reg_write:  ex_me_q.reg_write,
        mem_to_reg: ex_me_q.mem_to_reg,
        load_data:  dmem_rdata,
        alu_result: ex_me_q.alu_result,
        dst:        ex_me_q.dst
    };

    pipe_reg #(.T(me_wb_t)) u_me_wb (
        .clock (clock), .rst_n (rst_n),
        .hold  (1'b0), .bubble (1'b0),
        .d     (me_wb_d), .q (me_wb_q)
    );

    assign wb_data = me_wb_q.mem_to_reg ? me_wb_q.load_data : me_wb_q.alu_result; // Load or ALU

endmodule

`default_nettype wire

//--- sim/isa_model.svh
`ifndef ISA_MODEL_SVH
`define ISA_MODEL_SVH

localparam int          IMEM_WORDS  = 256;
localparam int          BODY_LEN    = 160;               // Random instructions after the prologue
localparam int          HALT_IDX    = 7 + BODY_LEN;      // Word index of the jump-to-self
localparam logic [31:0] HALT_ADDR   = 32'(HALT_IDX * 4);
localparam logic [31:0] DATA_BASE   = 32'h0000_1000;
localparam int          DATA_WORDS  = 16;
localparam int          MODEL_STEPS = 10000;             // Guard for the reference run

logic [31:0] imem [IMEM_WORDS];                          // Program image
logic [31:0] exp_addr [$];                               // Expected stores in program order
logic [31:0] exp_data [$];

// Power-up contents, every address bit takes part
function automatic logic [31:0] fill_word(input logic [31:0] a);
    return (a * 32'h9e37_79b9) ^ {a[15:0], a[31:16]} ^ 32'h5edc_0000;
endfunction

function automatic logic in_region(input logic [31:0] a);
    return a[31:6] == DATA_BASE[31:6];                   // 16 words, 64 bytes
endfunction

function automatic logic [5:0] rtype_funct(input int unsigned kind);
    case (kind)
        0:       return FN_ADDU;
        1:       return FN_SUBU;
        2:       return FN_AND;
        3:       return FN_OR;
        4:       return FN_XOR;
        default: return FN_SLT;
    endcase
endfunction

task automatic gen_program();
    int unsigned n;
    int unsigned kind;
    int unsigned tgt;
    logic [4:0]  rs;
    logic [4:0]  rt;
    logic [4:0]  rd;
    logic [15:0] dofs;
    logic        prev_ctl;
    for (n = 0; n < IMEM_WORDS; n++) begin
        imem[n] = '0;                                    // Zero word decodes as a no-operation
    end
    for (n = 1; n < 8; n++) begin
        imem[n - 1] = {OP_ADDIU, 5'd0, 5'(n), 16'($urandom)}; // Give r1..r7 known values
    end
    prev_ctl = 1'b0;
    for (n = 7; n < HALT_IDX; n++) begin
        rs   = 5'($urandom % 7 + 1);
        rt   = 5'($urandom % 7 + 1);
        rd   = 5'($urandom % 7 + 1);
        dofs = 16'(DATA_BASE + 4 * ($urandom % DATA_WORDS)); // Absolute address off r0
        tgt  = n + 2 + $urandom % 4;                     // Forward only, past the delay slot
        if (tgt > HALT_IDX) begin
            tgt = HALT_IDX;
        end
        kind = $urandom % 16;
        if (kind >= 13 && (prev_ctl || n + 1 >= HALT_IDX)) begin
            kind = 10;                                   // Nothing redirects from a delay slot
        end
        if (kind == 13 || kind == 14) begin
            case ($urandom % 3)
                0:       rt = rs;                        // Always equal
                1:       rt = 5'd0;
                default: ;
            endcase
        end
        prev_ctl = (kind >= 13);
        case (kind)
            0, 1, 2, 3, 4, 5: imem[n] = {OP_RTYPE, rs, rt, rd, 5'd0, rtype_funct(kind)};
            6, 7:             imem[n] = {OP_ADDIU, rs, rd, 16'($urandom)};
            8, 9:             imem[n] = {OP_LW, 5'd0, rd, dofs};
            13:               imem[n] = {OP_BEQ, rs, rt, 16'(tgt - n - 1)};
            14:               imem[n] = {OP_BNE, rs, rt, 16'(tgt - n - 1)};
            15:               imem[n] = {OP_J, 26'(tgt)};
            default:          imem[n] = {OP_SW, 5'd0, rt, dofs};
        endcase
    end
    imem[HALT_IDX] = {OP_J, 26'(HALT_IDX)};              // Spin here, next word stays a nop
endtask

// One instruction per step, npc carries the delay slot
task automatic run_model();
    logic [31:0] r [32];
    logic [31:0] mem [DATA_WORDS];
    logic [31:0] ins;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm;
    logic [31:0] ea;
    int          pc;
    int          npc;
    int          nnpc;
    int          steps;
    for (int i = 0; i < 32; i++) begin
        r[i] = '0;
    end
    for (int k = 0; k < DATA_WORDS; k++) begin
        mem[k] = fill_word(DATA_BASE + 32'(4 * k));
    end
    pc    = 0;
    npc   = 1;
    steps = 0;
    while (pc != HALT_IDX && steps < MODEL_STEPS) begin
        ins  = imem[pc];
        nnpc = npc + 1;
        a    = r[ins[25:21]];
        b    = r[ins[20:16]];
        imm  = {{16{ins[15]}}, ins[15:0]};
        ea   = a + imm;
        case (ins[31:26])
            OP_RTYPE: begin
                case (ins[5:0])
                    FN_ADDU: r[ins[15:11]] = a + b;
                    FN_SUBU: r[ins[15:11]] = a - b;
                    FN_AND:  r[ins[15:11]] = a & b;
                    FN_OR:   r[ins[15:11]] = a | b;
                    FN_XOR:  r[ins[15:11]] = a ^ b;
                    FN_SLT:  r[ins[15:11]] = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    default: ;
                endcase
            end
            OP_ADDIU: r[ins[20:16]] = ea;
            OP_LW:    r[ins[20:16]] = mem[ea[5:2]];
            OP_SW: begin
                mem[ea[5:2]] = b;
                exp_addr.push_back(ea);
                exp_data.push_back(b);
            end
            OP_BEQ:   if (a == b) nnpc = pc + 1 + int'($signed(ins[15:0]));
            OP_BNE:   if (a != b) nnpc = pc + 1 + int'($signed(ins[15:0]));
            OP_J:     nnpc = int'(ins[25:0]);
            default: ;
        endcase
        r[0]  = '0;
        pc    = npc;
        npc   = nnpc;
        steps = steps + 1;
    end
endtask

`endif

//--- sim/tb_mips_pipeline.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_cfg.svh"

module tb_mips_pipeline import cpu_pkg::*; ();

    localparam int HALT_TIMEOUT = 2000;                  // Cycles allowed to reach the halt loop
    localparam int DRAIN_CYCLES = 8;                     // Older instructions leave the pipe

    logic        clock;
    logic        rst_n;
    logic [31:0] inst_addr;
    logic [31:0] inst_data;
    logic [31:0] dmem_addr;
    logic [31:0] dmem_wdata;
    logic        dmem_write;
    logic        dmem_read;
    logic [31:0] dmem_rdata;

    int err_count    = 0;                                // Main flow
    int check_count  = 0;
    int store_err    = 0;                                // Store monitor
    int store_checks = 0;
    int got_count    = 0;
    int cycles       = 0;

    `include "isa_model.svh"

    logic [31:0] data_mem [DATA_WORDS];

    mips_pipeline dut_i (
        .clock      (clock),
        .rst_n      (rst_n),
        .inst_addr  (inst_addr),
        .inst_data  (inst_data),
        .dmem_addr  (dmem_addr),
        .dmem_wdata (dmem_wdata),
        .dmem_write (dmem_write),
        .dmem_read  (dmem_read),
        .dmem_rdata (dmem_rdata)
    );

    // Both memories answer in the same cycle
    assign inst_data  = (inst_addr < 32'(IMEM_WORDS * 4)) ? imem[inst_addr[9:2]] : '0;
    assign dmem_rdata = in_region(dmem_addr) ? data_mem[dmem_addr[5:2]] : fill_word(dmem_addr);

    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock;
    end

    // Strobe is stable by the falling edge, store lands before the next read
    always @(negedge clock) begin
        if (rst_n && dmem_write) begin
            if (got_count < exp_addr.size()) begin
                store_checks = store_checks + 2;
                if (dmem_addr != exp_addr[got_count]) begin
                    $display("[ERROR] t=%0t dmem_addr got %h expected %h",
                             $time, dmem_addr, exp_addr[got_count]);
                    store_err++;
                end
                if (dmem_wdata != exp_data[got_count]) begin
                    $display("[ERROR] t=%0t dmem_wdata got %h expected %h",
                             $time, dmem_wdata, exp_data[got_count]);
                    store_err++;
                end
            end else begin
                $display("Store %0d to %h at %0t is beyond the stores of the program",
                         got_count + 1, dmem_addr, $time);
                store_err++;
            end
            if (in_region(dmem_addr)) begin
                data_mem[dmem_addr[5:2]] = dmem_wdata;
            end
            got_count++;
        end
    end

    task automatic check_reset_state();
        check_count = check_count + 3;
        if (inst_addr != `CPU_RESET_PC) begin
            $display("[ERROR] t=%0t inst_addr got %h expected %h", $time, inst_addr, `CPU_RESET_PC);
            err_count++;
        end
        if (dmem_write != 1'b0) begin
            $display("[ERROR] t=%0t dmem_write got %b expected 0", $time, dmem_write);
            err_count++;
        end
        if (dmem_read != 1'b0) begin
            $display("[ERROR] t=%0t dmem_read got %b expected 0", $time, dmem_read);
            err_count++;
        end
    endtask

    initial begin
        rst_n = 1'b0;
        void'($urandom(32'h5edc));                       // Single seed for the whole run
        gen_program();
        run_model();
        for (int k = 0; k < DATA_WORDS; k++) begin
            data_mem[k] = fill_word(DATA_BASE + 32'(4 * k));
        end

        repeat (3) begin
            @(negedge clock);
            check_reset_state();
        end
        rst_n = 1'b1;
        check_reset_state();                             // Still the reset PC until the next edge

        while (inst_addr != HALT_ADDR && cycles < HALT_TIMEOUT) begin
            @(negedge clock);
            cycles++;
        end
        check_count++;
        if (inst_addr != HALT_ADDR) begin
            $display("Timeout: halt address %h not fetched within %0d cycles", HALT_ADDR, cycles);
            err_count++;
        end

        repeat (DRAIN_CYCLES) @(negedge clock);
        check_count++;
        if (got_count != exp_addr.size()) begin
            $display("Store count mismatch: observed %0d, model has %0d", got_count, exp_addr.size());
            err_count++;
        end

        $display("Summary: checks=%0d errors=%0d stores=%0d/%0d cycles=%0d",
                 check_count + store_checks, err_count + store_err, got_count,
                 exp_addr.size(), cycles);
        if (err_count + store_err == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sources.f
+incdir+src
+incdir+sim
src/cpu_pkg.sv
src/pipe_reg.sv
src/fetch_stage.sv
src/register_file.sv
src/decode_stage.sv
src/hazard_unit.sv
src/execute_stage.sv
src/mips_pipeline.sv
sim/tb_mips_pipeline.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the testbench with Verilator, then judge the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -j 0 --top-module tb_mips_pipeline --Mdir obj_dir -f sources.f \
    && ./obj_dir/Vtb_mips_pipeline > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "Build or run error"; exit 1; }
cat sim.log
grep -q "Verification failed" sim.log && exit 1 || exit 0
